//--- pwo_top.f
ntt_arith_pkg.sv
ntt_mem_pkg.sv
pwo_ctrl.sv
pwo_lane.sv
pwo_unit.sv
pwo_writeback.sv
pwo_top.sv
pwo_checker.sv
tb_pwo_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pwo_top
RTL_TOP   ?= pwo_top
FILELIST  ?= pwo_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
RTL_SRCS  ?= ntt_arith_pkg.sv ntt_mem_pkg.sv pwo_ctrl.sv pwo_lane.sv \
             pwo_unit.sv pwo_writeback.sv pwo_top.sv
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)

//--- tb_pwo_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pwo_top;

    localparam int NUM_WORDS   = 64;
    localparam int CYCLE_LIMIT = 2000;

    logic                     clk;
    logic                     reset_n;
    logic                     zeroize;
    logic                     enable;
    ntt_arith_pkg::pwo_mode_t mode;
    logic                     accumulate;
    ntt_mem_pkg::mem_addr_t   a_base;
    ntt_mem_pkg::mem_addr_t   b_base;
    ntt_mem_pkg::mem_addr_t   c_base;
    logic                     a_rd_en;
    logic                     b_rd_en;
    logic                     c_rd_en;
    logic                     wr_en;
    logic                     busy;
    logic                     done;
    ntt_mem_pkg::mem_addr_t   a_rd_addr;
    ntt_mem_pkg::mem_addr_t   b_rd_addr;
    ntt_mem_pkg::mem_addr_t   c_rd_addr;
    ntt_mem_pkg::mem_addr_t   wr_addr;
    ntt_mem_pkg::mem_word_u   a_rd_data;
    ntt_mem_pkg::mem_word_u   b_rd_data;
    ntt_mem_pkg::mem_word_u   c_rd_data;
    ntt_mem_pkg::mem_word_u   wr_data;
    logic [95:0]              mem_a [0:32767];
    logic [95:0]              mem_b [0:32767];
    logic [95:0]              mem_c [0:32767];
    int                       seed;
    int                       cycles;
    int                       tb_errors;
    int                       chk_errors;
    int                       done_count;

    always #20 clk = ~clk;

    pwo_top #(.SRAM_LATENCY(1), .NUM_WORDS(NUM_WORDS)) dut_i (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize), .enable_i(enable),
        .mode_i(mode), .accumulate_i(accumulate),
        .a_base_i(a_base), .b_base_i(b_base), .c_base_i(c_base),
        .pwm_a_rd_en_o(a_rd_en), .pwm_a_rd_addr_o(a_rd_addr), .pwm_a_rd_data_i(a_rd_data),
        .pwm_b_rd_en_o(b_rd_en), .pwm_b_rd_addr_o(b_rd_addr), .pwm_b_rd_data_i(b_rd_data),
        .mem_rd_en_o(c_rd_en), .mem_rd_addr_o(c_rd_addr), .mem_rd_data_i(c_rd_data),
        .mem_wr_en_o(wr_en), .mem_wr_addr_o(wr_addr), .mem_wr_data_o(wr_data),
        .busy_o(busy), .done_o(done)
    );

    pwo_checker #(.NUM_WORDS(NUM_WORDS)) u_checker (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize), .enable_i(enable),
        .mode_i(mode), .accumulate_i(accumulate),
        .a_base_i(a_base), .b_base_i(b_base), .c_base_i(c_base),
        .pwm_a_rd_en_i(a_rd_en), .pwm_a_rd_addr_i(a_rd_addr), .pwm_a_rd_data_i(a_rd_data),
        .pwm_b_rd_en_i(b_rd_en), .pwm_b_rd_addr_i(b_rd_addr), .pwm_b_rd_data_i(b_rd_data),
        .mem_rd_en_i(c_rd_en), .mem_rd_addr_i(c_rd_addr), .mem_rd_data_i(c_rd_data),
        .mem_wr_en_i(wr_en), .mem_wr_addr_i(wr_addr), .mem_wr_data_i(wr_data),
        .busy_i(busy), .done_i(done), .errors_o(chk_errors), .done_count_o(done_count)
    );

    // Memory models, one cycle read latency
    always @(posedge clk) begin
        if (a_rd_en) a_rd_data.flat <= mem_a[a_rd_addr];
        if (b_rd_en) b_rd_data.flat <= mem_b[b_rd_addr];
        if (c_rd_en) c_rd_data.flat <= mem_c[c_rd_addr];
        if (wr_en) mem_c[wr_addr] <= wr_data.flat;
    end

    task automatic report_and_finish;
        $display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            tb_errors++;
            report_and_finish();
        end
    end

    function automatic logic [95:0] random_word();
        logic [95:0] w;
        logic [31:0] r;
        w = '0;
        for (int i = 0; i < 4; i++) begin
            r = $unsigned($random(seed)) % 32'(ntt_arith_pkg::MLDSA_Q);
            w[i*24 +: 24] = {1'b0, r[22:0]};
        end
        return w;
    endfunction

    task automatic start_op(ntt_arith_pkg::pwo_mode_t m, logic acc,
                            ntt_mem_pkg::mem_addr_t dst);
        @(negedge clk);
        mode       = m;
        accumulate = acc;
        c_base     = dst;
        enable     = 1'b1;
        @(negedge clk);
        enable = 1'b0;
    endtask

    task automatic wait_done;
        do @(negedge clk); while (!done);
    endtask

    initial begin
        logic [95:0] edge_a;
        logic [95:0] edge_b;
        clk        = 1'b0;
        reset_n    = 1'b0;
        zeroize    = 1'b0;
        enable     = 1'b0;
        mode       = ntt_arith_pkg::PWO_MUL;
        accumulate = 1'b0;
        a_base     = 15'h0100;
        b_base     = 15'h0200;
        c_base     = 15'h0300;
        a_rd_data  = '0;
        b_rd_data  = '0;
        c_rd_data  = '0;
        seed       = 32'hf298_f40d;
        cycles     = 0;
        tb_errors  = 0;
        for (int k = 0; k < NUM_WORDS; k++) begin
            mem_a[256 + k]  = random_word();
            mem_b[512 + k]  = random_word();
            mem_c[768 + k]  = random_word();
            mem_c[1536 + k] = random_word();
        end
        // Edge values 0 and q-1 in the first word
        edge_a = {24'd0, 24'(ntt_arith_pkg::MLDSA_Q - 1), 24'(ntt_arith_pkg::MLDSA_Q - 1), 24'd0};
        edge_b = {24'd0, 24'd0, 24'(ntt_arith_pkg::MLDSA_Q - 1), 24'(ntt_arith_pkg::MLDSA_Q - 1)};
        mem_a[256] = edge_a;
        mem_b[512] = edge_b;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        start_op(ntt_arith_pkg::PWO_MUL, 1'b0, 15'h0300);
        wait_done();
        start_op(ntt_arith_pkg::PWO_MUL, 1'b1, 15'h0300);
        wait_done();
        start_op(ntt_arith_pkg::PWO_ADD, 1'b0, 15'h0400);
        // A second strobe while busy must be ignored
        repeat (10) @(negedge clk);
        mode   = ntt_arith_pkg::PWO_SUB;
        enable = 1'b1;
        @(negedge clk);
        enable = 1'b0;
        mode   = ntt_arith_pkg::PWO_ADD;
        wait_done();
        start_op(ntt_arith_pkg::PWO_SUB, 1'b0, 15'h0500);
        wait_done();

        // Zeroize partway, then a clean operation
        start_op(ntt_arith_pkg::PWO_MUL, 1'b1, 15'h0600);
        repeat (20) @(negedge clk);
        zeroize = 1'b1;
        @(negedge clk);
        zeroize = 1'b0;
        repeat (12) @(negedge clk);
        start_op(ntt_arith_pkg::PWO_SUB, 1'b0, 15'h0600);
        wait_done();
        repeat (5) @(negedge clk);

        if (done_count != 5) begin
            $display("Expected 5 done pulses but saw %0d", done_count);
            tb_errors++;
        end
        report_and_finish();
    end

endmodule

`default_nettype wire

//--- pwo_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pwo_checker #(
    parameter int NUM_WORDS = 64
) (
    input  wire                            clk,
    input  wire                            reset_n,
    input  wire                            zeroize_i,
    input  wire                            enable_i,
    input  wire ntt_arith_pkg::pwo_mode_t  mode_i,
    input  wire                            accumulate_i,
    input  wire ntt_mem_pkg::mem_addr_t    a_base_i,
    input  wire ntt_mem_pkg::mem_addr_t    b_base_i,
    input  wire ntt_mem_pkg::mem_addr_t    c_base_i,
    input  wire                            pwm_a_rd_en_i,
    input  wire ntt_mem_pkg::mem_addr_t    pwm_a_rd_addr_i,
    input  wire ntt_mem_pkg::mem_word_u    pwm_a_rd_data_i,
    input  wire                            pwm_b_rd_en_i,
    input  wire ntt_mem_pkg::mem_addr_t    pwm_b_rd_addr_i,
    input  wire ntt_mem_pkg::mem_word_u    pwm_b_rd_data_i,
    input  wire                            mem_rd_en_i,
    input  wire ntt_mem_pkg::mem_addr_t    mem_rd_addr_i,
    input  wire ntt_mem_pkg::mem_word_u    mem_rd_data_i,
    input  wire                            mem_wr_en_i,
    input  wire ntt_mem_pkg::mem_addr_t    mem_wr_addr_i,
    input  wire ntt_mem_pkg::mem_word_u    mem_wr_data_i,
    input  wire                            busy_i,
    input  wire                            done_i,
    output int                             errors_o,
    output int                             done_count_o
);

    ntt_arith_pkg::pwo_mode_t op_mode;
    logic                     op_acc;
    ntt_mem_pkg::mem_addr_t   op_a_base;
    ntt_mem_pkg::mem_addr_t   op_b_base;
    ntt_mem_pkg::mem_addr_t   op_c_base;
    logic                     rd_pend;
    logic                     prev_busy;
    logic                     prev_zeroize;
    logic                     prev_last_wr;
    int                       rd_left;
    int                       rd_count;
    int                       wr_count;
    logic [95:0]              exp_q [$];
    ntt_mem_pkg::mem_addr_t   addr_q [$];

    // ==============================
    // Reference model
    // ==============================
    function automatic logic [95:0] expected_word(ntt_arith_pkg::pwo_mode_t mode,
                                                  logic [95:0] a, logic [95:0] b,
                                                  logic [95:0] c);
        logic [95:0] w;
        logic [63:0] q;
        logic [63:0] la;
        logic [63:0] lb;
        logic [63:0] lc;
        logic [63:0] r;
        q = 64'(ntt_arith_pkg::MLDSA_Q);
        w = '0;
        for (int i = 0; i < 4; i++) begin
            la = 64'(a[i*24 +: 23]);
            lb = 64'(b[i*24 +: 23]);
            lc = 64'(c[i*24 +: 23]);
            case (mode)
                ntt_arith_pkg::PWO_MUL: r = (la * lb + lc) % q;
                ntt_arith_pkg::PWO_ADD: r = (la + lb) % q;
                ntt_arith_pkg::PWO_SUB: r = (la >= lb) ? la - lb : la + q - lb;
                default:                r = '0;
            endcase
            w[i*24 +: 24] = {1'b0, r[22:0]};
        end
        return w;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s expected %b got %b", $time, name, exp, got);
            errors_o++;
        end
    endtask

    task automatic check_addr(input string name, input ntt_mem_pkg::mem_addr_t got,
                              input ntt_mem_pkg::mem_addr_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s expected %h got %h", $time, name, exp, got);
            errors_o++;
        end
    endtask

    always @(posedge clk) begin
        logic [95:0]            exp_data;
        logic [95:0]            c_word;
        ntt_mem_pkg::mem_addr_t exp_addr;
        ntt_mem_pkg::mem_addr_t idx;
        logic                   exp_rd;
        logic                   exp_c_rd;
        if (!reset_n) begin
            errors_o     = 0;
            done_count_o = 0;
            rd_pend      = 1'b0;
            prev_busy    = 1'b0;
            prev_zeroize = 1'b0;
            prev_last_wr = 1'b0;
            rd_left      = 0;
            rd_count     = 0;
            wr_count     = 0;
            op_mode      = ntt_arith_pkg::PWO_MUL;
            op_acc       = 1'b0;
            op_a_base    = '0;
            op_b_base    = '0;
            op_c_base    = '0;
            exp_q.delete();
            addr_q.delete();
        end else begin
            // Compare each write against the oldest expected word
            if (mem_wr_en_i) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected write at %0t to address %h", $time, mem_wr_addr_i);
                    errors_o++;
                end else begin
                    exp_data = exp_q.pop_front();
                    exp_addr = addr_q.pop_front();
                    if (mem_wr_data_i.flat !== exp_data) begin
                        $display("Fail at %0t: mem_wr_data_o expected %h got %h",
                                 $time, exp_data, mem_wr_data_i.flat);
                        errors_o++;
                    end
                    if (mem_wr_addr_i !== exp_addr) begin
                        $display("Fail at %0t: mem_wr_addr_o expected %h got %h",
                                 $time, exp_addr, mem_wr_addr_i);
                        errors_o++;
                    end
                end
                wr_count++;
            end

            if (done_i) begin
                done_count_o++;
                if (busy_i !== 1'b0 || prev_busy !== 1'b1) begin
                    $display("Fail at %0t: busy_o did not fall with done_o", $time);
                    errors_o++;
                end
                if (!prev_last_wr || wr_count != NUM_WORDS) begin
                    $display("Fail at %0t: done_o after %0d writes, last write missing",
                             $time, wr_count);
                    errors_o++;
                end
            end

            if (prev_zeroize && busy_i) begin
                $display("Fail at %0t: busy_o expected 0 got 1", $time);
                errors_o++;
            end

            // Read data for the previous request is stable now
            if (rd_pend) begin
                c_word = (op_mode == ntt_arith_pkg::PWO_MUL && op_acc) ?
                         mem_rd_data_i.flat : '0;
                exp_q.push_back(expected_word(op_mode, pwm_a_rd_data_i.flat,
                                              pwm_b_rd_data_i.flat, c_word));
                addr_q.push_back(op_c_base + ntt_mem_pkg::mem_addr_t'(rd_count));
                rd_count++;
            end

            // Reads for word k follow the start by 1+k cycles, one per cycle
            exp_rd   = (rd_left > 0);
            exp_c_rd = exp_rd && op_mode == ntt_arith_pkg::PWO_MUL && op_acc;
            idx      = ntt_mem_pkg::mem_addr_t'(NUM_WORDS - rd_left);
            check_bit("pwm_a_rd_en_o", pwm_a_rd_en_i, exp_rd);
            check_bit("pwm_b_rd_en_o", pwm_b_rd_en_i, exp_rd);
            check_bit("mem_rd_en_o", mem_rd_en_i, exp_c_rd);
            if (exp_rd) begin
                check_addr("pwm_a_rd_addr_o", pwm_a_rd_addr_i, op_a_base + idx);
                check_addr("pwm_b_rd_addr_o", pwm_b_rd_addr_i, op_b_base + idx);
                rd_left--;
            end
            if (exp_c_rd) begin
                check_addr("mem_rd_addr_o", mem_rd_addr_i, op_c_base + idx);
            end

            prev_last_wr = mem_wr_en_i &&
                           (mem_wr_addr_i == op_c_base + ntt_mem_pkg::mem_addr_t'(NUM_WORDS - 1));
            rd_pend      = exp_rd;

            if (enable_i && !busy_i && !zeroize_i) begin
                op_mode   = mode_i;
                op_acc    = accumulate_i;
                op_a_base = a_base_i;
                op_b_base = b_base_i;
                op_c_base = c_base_i;
                rd_left   = NUM_WORDS;
                rd_count  = 0;
                wr_count  = 0;
            end

            // Zeroize drops everything still in flight
            if (zeroize_i) begin
                rd_pend = 1'b0;
                rd_left = 0;
                exp_q.delete();
                addr_q.delete();
            end
            prev_busy    = busy_i;
            prev_zeroize = zeroize_i;
        end
    end

endmodule

`default_nettype wire

//--- pwo_top.sv
`timescale 1ns/1ps
`default_nettype none

module pwo_top #(
    parameter int SRAM_LATENCY = 1,
    parameter int NUM_WORDS    = 64
) (
    input  wire                            clk,
    input  wire                            reset_n,
    input  wire                            zeroize_i,
    input  wire                            enable_i,
    input  wire ntt_arith_pkg::pwo_mode_t  mode_i,
    input  wire                            accumulate_i,
    input  wire ntt_mem_pkg::mem_addr_t    a_base_i,
    input  wire ntt_mem_pkg::mem_addr_t    b_base_i,
    input  wire ntt_mem_pkg::mem_addr_t    c_base_i,
    // Operand read ports
    output logic                           pwm_a_rd_en_o,
    output ntt_mem_pkg::mem_addr_t         pwm_a_rd_addr_o,
    input  wire ntt_mem_pkg::mem_word_u    pwm_a_rd_data_i,
    output logic                           pwm_b_rd_en_o,
    output ntt_mem_pkg::mem_addr_t         pwm_b_rd_addr_o,
    input  wire ntt_mem_pkg::mem_word_u    pwm_b_rd_data_i,
    // Destination memory, read for accumulate and written with results
    output logic                           mem_rd_en_o,
    output ntt_mem_pkg::mem_addr_t         mem_rd_addr_o,
    input  wire ntt_mem_pkg::mem_word_u    mem_rd_data_i,
    output logic                           mem_wr_en_o,
    output ntt_mem_pkg::mem_addr_t         mem_wr_addr_o,
    output ntt_mem_pkg::mem_word_u         mem_wr_data_o,
    output logic                           busy_o,
    output logic                           done_o
);

    logic                     rd_issue;
    ntt_mem_pkg::mem_addr_t   rd_offset;
    ntt_arith_pkg::pwo_mode_t mode;
    logic                     accumulate;
    ntt_mem_pkg::mem_word_u   result;
    logic                     last_write;

    // ==============================
    // Input side
    // ==============================
    pwo_ctrl #(
        .NUM_WORDS (NUM_WORDS)
    ) u_ctrl (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize_i       (zeroize_i),
        .enable_i        (enable_i),
        .mode_i          (mode_i),
        .accumulate_i    (accumulate_i),
        .a_base_i        (a_base_i),
        .b_base_i        (b_base_i),
        .last_write_i    (last_write),
        .pwm_a_rd_en_o   (pwm_a_rd_en_o),
        .pwm_a_rd_addr_o (pwm_a_rd_addr_o),
        .pwm_b_rd_en_o   (pwm_b_rd_en_o),
        .pwm_b_rd_addr_o (pwm_b_rd_addr_o),
        .mem_rd_en_o     (mem_rd_en_o),
        .rd_issue_o      (rd_issue),
        .rd_offset_o     (rd_offset),
        .mode_o          (mode),
        .accumulate_o    (accumulate),
        .busy_o          (busy_o),
        .done_o          (done_o)
    );

    // ==============================
    // Processing
    // ==============================
    pwo_unit u_unit (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize_i       (zeroize_i),
        .mode_i          (mode),
        .accumulate_i    (accumulate),
        .pwm_a_rd_data_i (pwm_a_rd_data_i),
        .pwm_b_rd_data_i (pwm_b_rd_data_i),
        .mem_rd_data_i   (mem_rd_data_i),
        .result_o        (result)
    );

    // ==============================
    // Output side
    // ==============================
    pwo_writeback #(
        .SRAM_LATENCY (SRAM_LATENCY),
        .NUM_WORDS    (NUM_WORDS)
    ) u_writeback (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize_i),
        .rd_issue_i    (rd_issue),
        .rd_offset_i   (rd_offset),
        .c_base_i      (c_base_i),
        .result_i      (result),
        .mem_rd_addr_o (mem_rd_addr_o),
        .mem_wr_en_o   (mem_wr_en_o),
        .mem_wr_addr_o (mem_wr_addr_o),
        .mem_wr_data_o (mem_wr_data_o),
        .last_write_o  (last_write)
    );

endmodule

`default_nettype wire

//--- pwo_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module pwo_writeback #(
    parameter int SRAM_LATENCY = 1,
    parameter int NUM_WORDS    = 64
) (
    input  wire                           clk,
    input  wire                           reset_n,
    input  wire                           zeroize_i,
    input  wire                           rd_issue_i,
    input  wire ntt_mem_pkg::mem_addr_t   rd_offset_i,
    input  wire ntt_mem_pkg::mem_addr_t   c_base_i,
    input  wire ntt_mem_pkg::mem_word_u   result_i,
    output ntt_mem_pkg::mem_addr_t        mem_rd_addr_o,
    output logic                          mem_wr_en_o,
    output ntt_mem_pkg::mem_addr_t        mem_wr_addr_o,
    output ntt_mem_pkg::mem_word_u        mem_wr_data_o,
    output logic                          last_write_o
);

    // Memory read latency, input register and two lane stages
    localparam int DELAY = SRAM_LATENCY + 3;
    localparam ntt_mem_pkg::mem_addr_t LAST_OFFSET = ntt_mem_pkg::mem_addr_t'(NUM_WORDS - 1);

    ntt_mem_pkg::mem_addr_t                                dest_addr;
    logic [DELAY-1:0]                                      wr_en_pipe;
    logic [DELAY-1:0]                                      last_pipe;
    logic [DELAY-1:0][ntt_mem_pkg::MEM_ADDR_WIDTH-1:0]     wr_addr_pipe;

    // Same address for the accumulate read and the later write
    assign dest_addr     = c_base_i + rd_offset_i;
    assign mem_rd_addr_o = dest_addr;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_en_pipe   <= '0;
            last_pipe    <= '0;
            wr_addr_pipe <= '0;
        end else if (zeroize_i) begin
            wr_en_pipe   <= '0;
            last_pipe    <= '0;
            wr_addr_pipe <= '0;
        end else begin
            wr_en_pipe   <= {wr_en_pipe[DELAY-2:0], rd_issue_i};
            last_pipe    <= {last_pipe[DELAY-2:0], rd_issue_i && (rd_offset_i == LAST_OFFSET)};
            wr_addr_pipe <= {wr_addr_pipe[DELAY-2:0], dest_addr};
        end
    end

    assign mem_wr_en_o   = wr_en_pipe[DELAY-1];
    assign mem_wr_addr_o = wr_addr_pipe[DELAY-1];
    assign mem_wr_data_o = result_i;
    assign last_write_o  = last_pipe[DELAY-1];

    // A read still issued after zeroize would reach the write port here
    a_no_write_after_zeroize: assert property (@(posedge clk) disable iff (!reset_n)
        zeroize_i |-> ##(DELAY+1) !mem_wr_en_o);

endmodule

`default_nettype wire

//--- pwo_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pwo_unit (
    input  wire                            clk,
    input  wire                            reset_n,
    input  wire                            zeroize_i,
    input  wire ntt_arith_pkg::pwo_mode_t  mode_i,
    input  wire                            accumulate_i,
    input  wire ntt_mem_pkg::mem_word_u    pwm_a_rd_data_i,
    input  wire ntt_mem_pkg::mem_word_u    pwm_b_rd_data_i,
    input  wire ntt_mem_pkg::mem_word_u    mem_rd_data_i,
    output ntt_mem_pkg::mem_word_u         result_o
);

    localparam int W = ntt_arith_pkg::COEFF_WIDTH;

    ntt_mem_pkg::mem_word_u a_q;
    ntt_mem_pkg::mem_word_u b_q;
    ntt_mem_pkg::mem_word_u c_q;
    logic                   acc_en;
    ntt_arith_pkg::coeff_t  lane_res [ntt_mem_pkg::LANES];

    // Read data enters here, one register deep
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            a_q <= '0;
            b_q <= '0;
            c_q <= '0;
        end else if (zeroize_i) begin
            a_q <= '0;
            b_q <= '0;
            c_q <= '0;
        end else begin
            a_q.flat <= pwm_a_rd_data_i.flat;
            b_q.flat <= pwm_b_rd_data_i.flat;
            c_q.flat <= mem_rd_data_i.flat;
        end
    end

    assign acc_en = accumulate_i && (mode_i == ntt_arith_pkg::PWO_MUL);

    for (genvar i = 0; i < ntt_mem_pkg::LANES; i++) begin : g_lane
        ntt_arith_pkg::coeff_t c_lane;

        // c port only carries real data in multiply-accumulate
        assign c_lane = acc_en ? c_q.lane[i][W-1:0] : '0;

        pwo_lane u_lane (
            .clk       (clk),
            .reset_n   (reset_n),
            .zeroize_i (zeroize_i),
            .mode_i    (mode_i),
            .a_i       (a_q.lane[i][W-1:0]),
            .b_i       (b_q.lane[i][W-1:0]),
            .c_i       (c_lane),
            .result_o  (lane_res[i])
        );

        a_lane_reduced: assert property (@(posedge clk) disable iff (!reset_n)
            (a_q.lane[i][W-1:0] < ntt_arith_pkg::MLDSA_Q) &&
            (b_q.lane[i][W-1:0] < ntt_arith_pkg::MLDSA_Q) &&
            (c_lane < ntt_arith_pkg::MLDSA_Q));
    end

    // Repack with a zero pad bit above each coefficient
    always_comb begin
        for (int i = 0; i < ntt_mem_pkg::LANES; i++) begin
            result_o.lane[i] = {1'b0, lane_res[i]};
        end
    end

endmodule

`default_nettype wire

//--- pwo_lane.sv
`timescale 1ns/1ps
`default_nettype none

module pwo_lane (
    input  wire                            clk,
    input  wire                            reset_n,
    input  wire                            zeroize_i,
    input  wire ntt_arith_pkg::pwo_mode_t  mode_i,
    input  wire ntt_arith_pkg::coeff_t     a_i,
    input  wire ntt_arith_pkg::coeff_t     b_i,
    input  wire ntt_arith_pkg::coeff_t     c_i,
    output ntt_arith_pkg::coeff_t          result_o
);

    localparam int W = ntt_arith_pkg::COEFF_WIDTH;
    localparam logic [2*W-1:0] Q_WIDE = (2*W)'(ntt_arith_pkg::MLDSA_Q);
    localparam logic [W:0]     Q_SUM  = (W+1)'(ntt_arith_pkg::MLDSA_Q);

    logic [2*W-1:0]        stage1_d;
    logic [2*W-1:0]        stage1_q;
    ntt_arith_pkg::coeff_t c_q;
    ntt_arith_pkg::coeff_t reduced;
    logic [W:0]            sum;

    // Stage 1: raw product, sum or difference
    always_comb begin
        case (mode_i)
            ntt_arith_pkg::PWO_MUL: stage1_d = (2*W)'(a_i) * (2*W)'(b_i);
            ntt_arith_pkg::PWO_ADD: stage1_d = (2*W)'(a_i) + (2*W)'(b_i);
            // Bias by q so the difference never goes negative
            ntt_arith_pkg::PWO_SUB: stage1_d = (2*W)'(a_i) + Q_WIDE - (2*W)'(b_i);
            default:                stage1_d = '0;
        endcase
    end

    // Stage 2: reduce, add the accumulate term, reduce once more
    assign reduced = ntt_arith_pkg::coeff_t'(stage1_q % Q_WIDE);
    assign sum     = {1'b0, reduced} + {1'b0, c_q};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            stage1_q <= '0;
            c_q      <= '0;
            result_o <= '0;
        end else if (zeroize_i) begin
            stage1_q <= '0;
            c_q      <= '0;
            result_o <= '0;
        end else begin
            stage1_q <= stage1_d;
            c_q      <= c_i;
            result_o <= (sum >= Q_SUM) ? W'(sum - Q_SUM) : W'(sum);
        end
    end

endmodule

`default_nettype wire

//--- pwo_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pwo_ctrl #(
    parameter int NUM_WORDS = 64
) (
    input  wire                              clk,
    input  wire                              reset_n,
    input  wire                              zeroize_i,
    input  wire                              enable_i,
    input  wire ntt_arith_pkg::pwo_mode_t    mode_i,
    input  wire                              accumulate_i,
    input  wire ntt_mem_pkg::mem_addr_t      a_base_i,
    input  wire ntt_mem_pkg::mem_addr_t      b_base_i,
    input  wire                              last_write_i,
    output logic                             pwm_a_rd_en_o,
    output ntt_mem_pkg::mem_addr_t           pwm_a_rd_addr_o,
    output logic                             pwm_b_rd_en_o,
    output ntt_mem_pkg::mem_addr_t           pwm_b_rd_addr_o,
    output logic                             mem_rd_en_o,
    output logic                             rd_issue_o,
    output ntt_mem_pkg::mem_addr_t           rd_offset_o,
    output ntt_arith_pkg::pwo_mode_t         mode_o,
    output logic                             accumulate_o,
    output logic                             busy_o,
    output logic                             done_o
);

    localparam ntt_mem_pkg::mem_addr_t LAST_OFFSET = ntt_mem_pkg::mem_addr_t'(NUM_WORDS - 1);

    logic                   start;
    ntt_mem_pkg::mem_addr_t a_base_q;
    ntt_mem_pkg::mem_addr_t b_base_q;

    // Strobe is ignored while an operation is running
    assign start = enable_i && !busy_o;

    // ==============================
    // Word counter and status
    // ==============================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_o      <= 1'b0;
            done_o      <= 1'b0;
            rd_issue_o  <= 1'b0;
            rd_offset_o <= '0;
        end else if (zeroize_i) begin
            busy_o      <= 1'b0;
            done_o      <= 1'b0;
            rd_issue_o  <= 1'b0;
            rd_offset_o <= '0;
        end else begin
            done_o <= last_write_i;
            if (start) begin
                busy_o      <= 1'b1;
                rd_issue_o  <= 1'b1;
                rd_offset_o <= '0;
            end else begin
                if (last_write_i) begin
                    busy_o <= 1'b0;
                end
                // One read per cycle, stop after the last word
                if (rd_issue_o && rd_offset_o == LAST_OFFSET) begin
                    rd_issue_o <= 1'b0;
                end else if (rd_issue_o) begin
                    rd_offset_o <= rd_offset_o + 1'b1;
                end
            end
        end
    end

    // Operation setup, held for the whole run
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mode_o       <= ntt_arith_pkg::PWO_MUL;
            accumulate_o <= 1'b0;
            a_base_q     <= '0;
            b_base_q     <= '0;
        end else if (zeroize_i) begin
            mode_o       <= ntt_arith_pkg::PWO_MUL;
            accumulate_o <= 1'b0;
            a_base_q     <= '0;
            b_base_q     <= '0;
        end else if (start) begin
            mode_o       <= mode_i;
            accumulate_o <= accumulate_i;
            a_base_q     <= a_base_i;
            b_base_q     <= b_base_i;
        end
    end

    assign pwm_a_rd_en_o   = rd_issue_o;
    assign pwm_a_rd_addr_o = a_base_q + rd_offset_o;
    assign pwm_b_rd_en_o   = rd_issue_o;
    assign pwm_b_rd_addr_o = b_base_q + rd_offset_o;

    // Old destination word is only needed for multiply-accumulate
    assign mem_rd_en_o = rd_issue_o && accumulate_o && (mode_o == ntt_arith_pkg::PWO_MUL);

    a_start_mode_valid: assert property (@(posedge clk) disable iff (!reset_n)
        enable_i |-> mode_i inside {ntt_arith_pkg::PWO_MUL, ntt_arith_pkg::PWO_ADD,
                                    ntt_arith_pkg::PWO_SUB});

endmodule

`default_nettype wire

//--- ntt_mem_pkg.sv
`default_nettype none

package ntt_mem_pkg;

    // ==============================
    // Memory addressing
    // ==============================

    localparam int MEM_ADDR_WIDTH = 15;

    typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;

    // ==============================
    // Memory word layout
    // ==============================

    // Four coefficients per word
    localparam int LANES = 4;

    // Coefficient in bits 22:0, bit 23 is a zero pad
    localparam int LANE_WIDTH = 24;

    // Lane 0 sits in the low bits of the flat view
    typedef union packed {
        logic [LANES*LANE_WIDTH-1:0]       flat;
        logic [LANES-1:0][LANE_WIDTH-1:0]  lane;
    } mem_word_u;

endpackage

`default_nettype wire

//--- ntt_arith_pkg.sv
`default_nettype none

package ntt_arith_pkg;

    // ==============================
    // Coefficient arithmetic
    // ==============================

    // Width of a fully reduced coefficient
    localparam int COEFF_WIDTH = 23;

    typedef logic [COEFF_WIDTH-1:0] coeff_t;

    // ML-DSA modulus, q = 2^23 - 2^13 + 1
    localparam coeff_t MLDSA_Q = 23'd8380417;

    // ==============================
    // Pointwise operation modes
    // ==============================

    // Encoding 2'b11 is unused
    typedef enum logic [1:0] {
        PWO_MUL = 2'b00,
        PWO_ADD = 2'b01,
        PWO_SUB = 2'b10
    } pwo_mode_t;

endpackage

`default_nettype wire
